// ==== dtlb.sv ====
// fully associative data TLB with ASID tags and 4K/2M/1G pages, looked up combinationally, filled by strobe
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defs.svh"

module dtlb import mmu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // clears every entry, wins over an update
    input  logic   flush_i,
    // update port, writes the entry named by the round-robin pointer
    input  logic   update_valid_i,
    input  vpn_t   update_vpn_i,
    input  asid_t  update_asid_i,
    input  ppn_t   update_ppn_i,
    input  perm_t  update_perm_i,
    input  logic   update_is_2m_i,
    input  logic   update_is_1g_i,
    // lookup port, zero latency
    input  vaddr_t lu_vaddr_i,
    input  asid_t  lu_asid_i,
    output logic   lu_hit_o,
    output ppn_t   lu_ppn_o,
    output perm_t  lu_perm_o,
    output logic   lu_is_2m_o,
    output logic   lu_is_1g_o
);

    // ------------------------------------------------------------------------
    // entry storage
    // ------------------------------------------------------------------------
    // tags
    vpn_t  tag_vpn_q  [`MMU_TLB_ENTRIES];
    asid_t tag_asid_q [`MMU_TLB_ENTRIES];
    logic  [`MMU_TLB_ENTRIES-1:0] tag_2m_q;
    logic  [`MMU_TLB_ENTRIES-1:0] tag_1g_q;
    logic  [`MMU_TLB_ENTRIES-1:0] valid_q;
    // contents
    ppn_t  ppn_q  [`MMU_TLB_ENTRIES];
    perm_t perm_q [`MMU_TLB_ENTRIES];

    // replacement pointer
    logic [$clog2(`MMU_TLB_ENTRIES)-1:0] rr_q;

    vpn_t lu_vpn;
    logic [`MMU_TLB_ENTRIES-1:0] hit;

    assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_PG_OFFS];

    // ------------------------------------------------------------------------
    // parallel tag compare
    // ------------------------------------------------------------------------
    always_comb begin : tag_compare
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            // vpn[2] always has to match
            hit[i] = valid_q[i] && (tag_asid_q[i] == lu_asid_i)
                && (tag_vpn_q[i][3*`MMU_VPN_LVL-1:2*`MMU_VPN_LVL]
                    == lu_vpn[3*`MMU_VPN_LVL-1:2*`MMU_VPN_LVL]);
            // giga pages ignore vpn[1] and vpn[0]
            if (!tag_1g_q[i]) begin
                hit[i] = hit[i] && (tag_vpn_q[i][2*`MMU_VPN_LVL-1:`MMU_VPN_LVL]
                    == lu_vpn[2*`MMU_VPN_LVL-1:`MMU_VPN_LVL]);
            end
            // mega pages ignore only vpn[0]
            if (!tag_1g_q[i] && !tag_2m_q[i]) begin
                hit[i] = hit[i] && (tag_vpn_q[i][`MMU_VPN_LVL-1:0]
                    == lu_vpn[`MMU_VPN_LVL-1:0]);
            end
        end
    end

    // one-hot mux of the hitting entry, zeros on a miss
    always_comb begin : hit_mux
        lu_ppn_o   = '0;
        lu_perm_o  = '0;
        lu_is_2m_o = 1'b0;
        lu_is_1g_o = 1'b0;
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            if (hit[i]) begin
                lu_ppn_o   = ppn_q[i];
                lu_perm_o  = perm_q[i];
                lu_is_2m_o = tag_2m_q[i];
                lu_is_1g_o = tag_1g_q[i];
            end
        end
    end

    assign lu_hit_o = |hit;

    // ------------------------------------------------------------------------
    // update, flush and replacement
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[rr_q] <= 1'b1;
            // wrap for any entry count, not only powers of two
            if (int'(rr_q) == `MMU_TLB_ENTRIES - 1) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

    // tag and payload write, only meaningful while the valid bit is set
    always_ff @(posedge clk_i) begin
        if (update_valid_i && !flush_i) begin
            tag_vpn_q[rr_q]  <= update_vpn_i;
            tag_asid_q[rr_q] <= update_asid_i;
            tag_2m_q[rr_q]   <= update_is_2m_i;
            tag_1g_q[rr_q]   <= update_is_1g_i;
            ppn_q[rr_q]      <= update_ppn_i;
            perm_q[rr_q]     <= update_perm_i;
        end
    end

    // a page is either 2M or 1G, never both
    a_update_one_size : assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_valid_i |-> !(update_is_2m_i && update_is_1g_i));

    // the fill agent must never install overlapping translations
    a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit));

endmodule

`default_nettype wire

// ==== lsu_xlate.sv ====
// load/store translation stage: registers the request and TLB answer, builds paddr and page faults
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defs.svh"

module lsu_xlate import mmu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      en_ld_st_translation_i,
    // request from the load/store unit
    input  logic      lsu_req_i,
    input  vaddr_t    lsu_vaddr_i,
    input  logic      lsu_is_store_i,
    input  logic      misaligned_valid_i,
    input  cause_t    misaligned_cause_i,
    input  tval_t     misaligned_tval_i,
    input  priv_lvl_e ld_st_priv_lvl_i,
    input  logic      sum_i,
    // lookup result of the same cycle
    input  logic      tlb_hit_i,
    input  ppn_t      tlb_ppn_i,
    input  perm_t     tlb_perm_i,
    input  logic      tlb_is_2m_i,
    input  logic      tlb_is_1g_i,
    // cycle 0
    output logic      lsu_dtlb_hit_o,
    output ppn_t      lsu_dtlb_ppn_o,
    // cycle 1
    output logic      lsu_valid_o,
    output paddr_t    lsu_paddr_o,
    output logic      lsu_ex_valid_o,
    output cause_t    lsu_ex_cause_o,
    output tval_t     lsu_ex_tval_o,
    output logic      dtlb_miss_o
);

    // large pages take the low vpn levels straight from the vaddr
    function automatic ppn_t compose_ppn(input ppn_t ppn, input vaddr_t va,
                                         input logic is_2m, input logic is_1g);
        ppn_t res;
        res = ppn;
        if (is_2m) begin
            res[`MMU_VPN_LVL-1:0] = va[`MMU_PG_OFFS+`MMU_VPN_LVL-1:`MMU_PG_OFFS];
        end
        if (is_1g) begin
            res[2*`MMU_VPN_LVL-1:0] = va[`MMU_PG_OFFS+2*`MMU_VPN_LVL-1:`MMU_PG_OFFS];
        end
        return res;
    endfunction

    // control state
    logic   req_q;
    logic   mis_valid_q;
    logic   hit_q;
    // payload
    vaddr_t vaddr_q;
    logic   is_store_q;
    cause_t mis_cause_q;
    tval_t  mis_tval_q;
    ppn_t   ppn_q;
    perm_t  perm_q;
    logic   is_2m_q;
    logic   is_1g_q;

    logic   daccess_err;
    tval_t  pf_tval;

    // ------------------------------------------------------------------------
    // cycle 0
    // ------------------------------------------------------------------------
    // untranslated accesses are always ready
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? tlb_hit_i : 1'b1;
    assign lsu_dtlb_ppn_o = en_ld_st_translation_i
        ? compose_ppn(tlb_ppn_i, lsu_vaddr_i, tlb_is_2m_i, tlb_is_1g_i)
        : ppn_t'(lsu_vaddr_i[`MMU_VLEN-1:`MMU_PG_OFFS]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q       <= 1'b0;
            mis_valid_q <= 1'b0;
            hit_q       <= 1'b0;
        end else begin
            req_q       <= lsu_req_i;
            // a misaligned flag without a request is noise
            mis_valid_q <= misaligned_valid_i && lsu_req_i;
            hit_q       <= tlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q     <= lsu_vaddr_i;
        is_store_q  <= lsu_is_store_i;
        mis_cause_q <= misaligned_cause_i;
        mis_tval_q  <= misaligned_tval_i;
        ppn_q       <= tlb_ppn_i;
        perm_q      <= tlb_perm_i;
        is_2m_q     <= tlb_is_2m_i;
        is_1g_q     <= tlb_is_1g_i;
    end

    // ------------------------------------------------------------------------
    // cycle 1
    // ------------------------------------------------------------------------
    // supervisor touching a user page without SUM, or user touching a kernel page
    assign daccess_err = ((ld_st_priv_lvl_i == PRIV_S) && !sum_i && perm_q[`MMU_PTE_U])
                      || ((ld_st_priv_lvl_i == PRIV_U) && !perm_q[`MMU_PTE_U]);

    // page faults report the sign-extended vaddr
    assign pf_tval = {{(`MMU_XLEN-`MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};

    always_comb begin : result
        // pass-through unless translation is on and no misaligned fault is pending
        lsu_valid_o    = req_q;
        lsu_paddr_o    = paddr_t'(vaddr_q);
        lsu_ex_valid_o = mis_valid_q;
        lsu_ex_cause_o = mis_cause_q;
        lsu_ex_tval_o  = mis_tval_q;
        dtlb_miss_o    = 1'b0;

        if (en_ld_st_translation_i && !mis_valid_q) begin
            lsu_valid_o    = 1'b0;
            lsu_ex_valid_o = 1'b0;
            lsu_paddr_o    = {compose_ppn(ppn_q, vaddr_q, is_2m_q, is_1g_q),
                              vaddr_q[`MMU_PG_OFFS-1:0]};
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                // stores also need a writable and already dirty page
                if (is_store_q) begin
                    if (daccess_err || !perm_q[`MMU_PTE_W] || !perm_q[`MMU_PTE_D]) begin
                        lsu_ex_valid_o = 1'b1;
                        lsu_ex_cause_o = `MMU_CAUSE_ST_PF;
                        lsu_ex_tval_o  = pf_tval;
                    end
                end else if (daccess_err) begin
                    lsu_ex_valid_o = 1'b1;
                    lsu_ex_cause_o = `MMU_CAUSE_LD_PF;
                    lsu_ex_tval_o  = pf_tval;
                end
            end else if (req_q) begin
                // request dropped, the requester fills the TLB and retries
                dtlb_miss_o = 1'b1;
            end
        end
    end

    // an exception always travels with a valid result
    a_ex_implies_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ex_valid_o |-> lsu_valid_o);

endmodule

`default_nettype wire

// ==== mmu.f ====
+incdir+.
mmu_pkg.sv
dtlb.sv
lsu_xlate.sv
mmu.sv
tb_clk_gen.sv
tb_checker.sv
tb_mmu.sv

// ==== mmu.sv ====
// data-side Sv39 MMU top level, connects the DTLB lookup and update port to the translation stage
`timescale 1ns/1ps
`default_nettype none

module mmu import mmu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      en_ld_st_translation_i,
    input  logic      flush_tlb_i,
    input  asid_t     asid_i,
    // load/store request
    input  logic      lsu_req_i,
    input  vaddr_t    lsu_vaddr_i,
    input  logic      lsu_is_store_i,
    input  logic      misaligned_valid_i,
    input  cause_t    misaligned_cause_i,
    input  tval_t     misaligned_tval_i,
    input  priv_lvl_e ld_st_priv_lvl_i,
    input  logic      sum_i,
    // TLB fill from outside
    input  logic      update_valid_i,
    input  vpn_t      update_vpn_i,
    input  asid_t     update_asid_i,
    input  ppn_t      update_ppn_i,
    input  perm_t     update_perm_i,
    input  logic      update_is_2m_i,
    input  logic      update_is_1g_i,
    // cycle 0
    output logic      lsu_dtlb_hit_o,
    output ppn_t      lsu_dtlb_ppn_o,
    // cycle 1
    output logic      lsu_valid_o,
    output paddr_t    lsu_paddr_o,
    output logic      lsu_ex_valid_o,
    output cause_t    lsu_ex_cause_o,
    output tval_t     lsu_ex_tval_o,
    output logic      dtlb_miss_o
);

    // lookup answer for the request in flight at cycle 0
    logic  tlb_hit;
    ppn_t  tlb_ppn;
    perm_t tlb_perm;
    logic  tlb_is_2m;
    logic  tlb_is_1g;

    dtlb i_dtlb (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_tlb_i    ),
        .update_valid_i ( update_valid_i ),
        .update_vpn_i   ( update_vpn_i   ),
        .update_asid_i  ( update_asid_i  ),
        .update_ppn_i   ( update_ppn_i   ),
        .update_perm_i  ( update_perm_i  ),
        .update_is_2m_i ( update_is_2m_i ),
        .update_is_1g_i ( update_is_1g_i ),
        .lu_vaddr_i     ( lsu_vaddr_i    ),
        .lu_asid_i      ( asid_i         ),
        .lu_hit_o       ( tlb_hit        ),
        .lu_ppn_o       ( tlb_ppn        ),
        .lu_perm_o      ( tlb_perm       ),
        .lu_is_2m_o     ( tlb_is_2m      ),
        .lu_is_1g_o     ( tlb_is_1g      )
    );

    lsu_xlate i_lsu_xlate (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .lsu_req_i              ( lsu_req_i              ),
        .lsu_vaddr_i            ( lsu_vaddr_i            ),
        .lsu_is_store_i         ( lsu_is_store_i         ),
        .misaligned_valid_i     ( misaligned_valid_i     ),
        .misaligned_cause_i     ( misaligned_cause_i     ),
        .misaligned_tval_i      ( misaligned_tval_i      ),
        .ld_st_priv_lvl_i       ( ld_st_priv_lvl_i       ),
        .sum_i                  ( sum_i                  ),
        .tlb_hit_i              ( tlb_hit                ),
        .tlb_ppn_i              ( tlb_ppn                ),
        .tlb_perm_i             ( tlb_perm               ),
        .tlb_is_2m_i            ( tlb_is_2m              ),
        .tlb_is_1g_i            ( tlb_is_1g              ),
        .lsu_dtlb_hit_o         ( lsu_dtlb_hit_o         ),
        .lsu_dtlb_ppn_o         ( lsu_dtlb_ppn_o         ),
        .lsu_valid_o            ( lsu_valid_o            ),
        .lsu_paddr_o            ( lsu_paddr_o            ),
        .lsu_ex_valid_o         ( lsu_ex_valid_o         ),
        .lsu_ex_cause_o         ( lsu_ex_cause_o         ),
        .lsu_ex_tval_o          ( lsu_ex_tval_o          ),
        .dtlb_miss_o            ( dtlb_miss_o            )
    );

endmodule

`default_nettype wire

// ==== mmu_defs.svh ====
// Sv39 widths, TLB size, PTE permission bit positions and fault causes, included wherever they are needed
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// ------------------------------------------------------------------------
// address widths
// ------------------------------------------------------------------------
// Sv39 virtual address
`define MMU_VLEN 39
// physical address
`define MMU_PLEN 56
// physical page number, plen minus page offset
`define MMU_PPNW 44
// trap value register width
`define MMU_XLEN 64
// 4K page offset
`define MMU_PG_OFFS 12
// one level of the three-level vpn
`define MMU_VPN_LVL 9

// ------------------------------------------------------------------------
// TLB geometry
// ------------------------------------------------------------------------
`define MMU_TLB_ENTRIES 4
`define MMU_ASIDW 1

// bit positions inside the 4-bit permission word kept per entry
`define MMU_PTE_U 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_D 3

// page fault causes as in the privileged spec
`define MMU_CAUSE_LD_PF 6'd13
`define MMU_CAUSE_ST_PF 6'd15

`endif

// ==== mmu_pkg.sv ====
// shared types of the data-side MMU, imported by the RTL modules and the testbench
`default_nettype none
`include "mmu_defs.svh"

package mmu_pkg;

    // ------------------------------------------------------------------------
    // address and page number types
    // ------------------------------------------------------------------------
    // virtual address as seen by the load/store unit
    typedef logic [`MMU_VLEN-1:0] vaddr_t;
    // translated physical address
    typedef logic [`MMU_PLEN-1:0] paddr_t;
    // physical page number, the part of paddr above the page offset
    typedef logic [`MMU_PPNW-1:0] ppn_t;
    // three vpn levels of 9 bits each
    typedef logic [3*`MMU_VPN_LVL-1:0] vpn_t;
    // address space id of the running context
    typedef logic [`MMU_ASIDW-1:0] asid_t;

    // ------------------------------------------------------------------------
    // permission and exception types
    // ------------------------------------------------------------------------
    // u, r, w and d bits, indexed by the MMU_PTE_* positions
    typedef logic [3:0] perm_t;
    // exception cause code
    typedef logic [5:0] cause_t;
    // exception trap value
    typedef logic [`MMU_XLEN-1:0] tval_t;

    // privilege level of the load/store access, encoded as in mstatus.mpp
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

endpackage

`default_nettype wire

// ==== mmu_stimulus.txt ====
# c en priv sum asid | u vpn asid ppn perm 2m 1g | f | r req vaddr st misv mcause mtval
# r expected: hit dppn valid paddr exv cause tval miss, all fields hex
c 0 1 0 0
r 1 4012345678 0 0 0 0  1 4012345 1 4012345678 0 0 0 0
u 0000123 0 abcde f 0 0
u 0040a00 0 80200 e 1 0
u 0080000 0 12340000 3 0 1
c 1 1 1 0
r 1 123abc 0 0 0 0  1 abcde 1 abcdeabc 0 0 0 0
r 1 40bff010 0 0 0 0  1 803ff 1 803ff010 0 0 0 0
r 1 94a33777 0 0 0 0  1 12354a33 1 12354a33777 0 0 0 0
r 1 94a33777 1 0 0 0  1 12354a33 1 12354a33777 1 f 94a33777 0
r 1 5000000000 0 0 0 0  0 0 0 0 0 0 0 1
c 1 1 1 1
r 1 123abc 0 0 0 0  0 0 0 0 0 0 0 1
c 1 0 0 0
u 7fffff0 0 55555 7 0 0
r 1 123abc 0 0 0 0  1 abcde 1 abcdeabc 0 0 0 0
r 1 123abc 1 0 0 0  1 abcde 1 abcdeabc 0 0 0 0
r 1 40bff010 0 0 0 0  1 803ff 1 803ff010 1 d 40bff010 0
r 1 40bff010 1 0 0 0  1 803ff 1 803ff010 1 f 40bff010 0
r 1 7fffff0008 1 0 0 0  1 55555 1 55555008 1 f ffffffffffff0008 0
r 1 7fffff0008 0 0 0 0  1 55555 1 55555008 0 0 0 0
c 1 1 0 0
r 1 123abc 0 0 0 0  1 abcde 1 abcdeabc 1 d 123abc 0
r 1 40bff010 0 0 0 0  1 803ff 1 803ff010 0 0 0 0
r 1 40bff010 1 0 0 0  1 803ff 1 803ff010 0 0 0 0
r 1 123abd 0 1 4 123abd  1 abcde 1 123abd 1 4 123abd 0
r 0 123abc 0 1 4 123abc  1 abcde 0 0 0 0 0 0
f
r 1 123abc 0 0 0 0  0 0 0 0 0 0 0 1

// ==== tb_checker.sv ====
// testbench checker: compares the MMU outputs with the expected values of each request
`timescale 1ns/1ps
`default_nettype none

module tb_checker import mmu_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    // expected values, qualified by chk_i in the request cycle
    input  logic   chk_i,
    input  logic   exp_hit_i,
    input  ppn_t   exp_dppn_i,
    input  logic   exp_valid_i,
    input  paddr_t exp_paddr_i,
    input  logic   exp_ex_valid_i,
    input  cause_t exp_cause_i,
    input  tval_t  exp_tval_i,
    input  logic   exp_miss_i,
    // DUT outputs
    input  logic   dtlb_hit_i,
    input  ppn_t   dtlb_ppn_i,
    input  logic   valid_i,
    input  paddr_t paddr_i,
    input  logic   ex_valid_i,
    input  cause_t ex_cause_i,
    input  tval_t  ex_tval_i,
    input  logic   miss_i,
    output int     error_count_o
);

    int     checks;
    // expected result of the request one cycle back
    logic   pend_q;
    logic   pend_valid;
    paddr_t pend_paddr;
    logic   pend_exv;
    cause_t pend_cause;
    tval_t  pend_tval;
    logic   pend_miss;

    task automatic compare(input string name, input logic [63:0] exp,
                           input logic [63:0] got);
        checks++;
        if (got !== exp) begin
            error_count_o++;
            $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic print_summary(input int tb_errors);
        $display("checks: %0d  mismatches: %0d  testbench errors: %0d",
                 checks, error_count_o, tb_errors);
    endtask

    initial begin
        error_count_o = 0;
        checks        = 0;
        pend_q        = 1'b0;
    end

    // ------------------------------------------------------------------------
    // sampling at the falling edge, away from input changes and clock edges
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni === 1'b1) begin
            if (pend_q) begin
                // result cycle of the previous request
                compare("lsu_valid_o", pend_valid, valid_i);
                if (pend_valid) begin
                    compare("lsu_paddr_o", pend_paddr, paddr_i);
                end
                compare("lsu_ex_valid_o", pend_exv, ex_valid_i);
                if (pend_exv) begin
                    compare("lsu_ex_cause_o", pend_cause, ex_cause_i);
                    compare("lsu_ex_tval_o", pend_tval, ex_tval_i);
                end
                compare("dtlb_miss_o", pend_miss, miss_i);
            end else begin
                // nothing in flight, so all strobes stay low
                compare("lsu_valid_o", 64'd0, valid_i);
                compare("lsu_ex_valid_o", 64'd0, ex_valid_i);
                compare("dtlb_miss_o", 64'd0, miss_i);
            end
            if (chk_i) begin
                // cycle-0 outputs of the current request
                compare("lsu_dtlb_hit_o", exp_hit_i, dtlb_hit_i);
                if (exp_hit_i) begin
                    compare("lsu_dtlb_ppn_o", exp_dppn_i, dtlb_ppn_i);
                end
                pend_valid = exp_valid_i;
                pend_paddr = exp_paddr_i;
                pend_exv   = exp_ex_valid_i;
                pend_cause = exp_cause_i;
                pend_tval  = exp_tval_i;
                pend_miss  = exp_miss_i;
            end
            pend_q = chk_i;
        end
    end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// testbench clock and reset source, one instance in the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #4 clk_o = ~clk_o;
        end
    end

    // reset held for 10 cycles, released just after an edge
    initial begin
        rst_no = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_mmu.sv ====
// testbench top: replays the stimulus file against the MMU and feeds expected results to the checker
`timescale 1ns/1ps
`default_nettype none
`include "mmu_defs.svh"

module tb_mmu import mmu_pkg::*; ();

    localparam int RESET_TIMEOUT = 50;
    localparam int OP_LIMIT      = 200;

    logic      clk;
    logic      rst_n;
    // DUT inputs
    logic      en_xlate;
    logic      flush_tlb;
    asid_t     asid;
    logic      lsu_req;
    vaddr_t    lsu_vaddr;
    logic      lsu_is_store;
    logic      mis_valid;
    cause_t    mis_cause;
    tval_t     mis_tval;
    priv_lvl_e priv_lvl;
    logic      sum;
    logic      upd_valid;
    vpn_t      upd_vpn;
    asid_t     upd_asid;
    ppn_t      upd_ppn;
    perm_t     upd_perm;
    logic      upd_2m;
    logic      upd_1g;
    // DUT outputs
    logic      dtlb_hit;
    ppn_t      dtlb_ppn;
    logic      lsu_valid;
    paddr_t    lsu_paddr;
    logic      ex_valid;
    cause_t    ex_cause;
    tval_t     ex_tval;
    logic      dtlb_miss;
    // expected values for the checker
    logic      chk;
    logic      exp_hit;
    ppn_t      exp_dppn;
    logic      exp_valid;
    paddr_t    exp_paddr;
    logic      exp_exv;
    cause_t    exp_cause;
    tval_t     exp_tval;
    logic      exp_miss;
    int        checker_errors;
    int        tb_errors;
    // hex fields of the current stimulus line
    logic [`MMU_XLEN-1:0] fld [14];

    tb_clk_gen i_clk_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    mmu dut0 (
        .clk_i                  ( clk          ),
        .rst_ni                 ( rst_n        ),
        .en_ld_st_translation_i ( en_xlate     ),
        .flush_tlb_i            ( flush_tlb    ),
        .asid_i                 ( asid         ),
        .lsu_req_i              ( lsu_req      ),
        .lsu_vaddr_i            ( lsu_vaddr    ),
        .lsu_is_store_i         ( lsu_is_store ),
        .misaligned_valid_i     ( mis_valid    ),
        .misaligned_cause_i     ( mis_cause    ),
        .misaligned_tval_i      ( mis_tval     ),
        .ld_st_priv_lvl_i       ( priv_lvl     ),
        .sum_i                  ( sum          ),
        .update_valid_i         ( upd_valid    ),
        .update_vpn_i           ( upd_vpn      ),
        .update_asid_i          ( upd_asid     ),
        .update_ppn_i           ( upd_ppn      ),
        .update_perm_i          ( upd_perm     ),
        .update_is_2m_i         ( upd_2m       ),
        .update_is_1g_i         ( upd_1g       ),
        .lsu_dtlb_hit_o         ( dtlb_hit     ),
        .lsu_dtlb_ppn_o         ( dtlb_ppn     ),
        .lsu_valid_o            ( lsu_valid    ),
        .lsu_paddr_o            ( lsu_paddr    ),
        .lsu_ex_valid_o         ( ex_valid     ),
        .lsu_ex_cause_o         ( ex_cause     ),
        .lsu_ex_tval_o          ( ex_tval      ),
        .dtlb_miss_o            ( dtlb_miss    )
    );

    tb_checker i_checker (
        .clk_i          ( clk            ),
        .rst_ni         ( rst_n          ),
        .chk_i          ( chk            ),
        .exp_hit_i      ( exp_hit        ),
        .exp_dppn_i     ( exp_dppn       ),
        .exp_valid_i    ( exp_valid      ),
        .exp_paddr_i    ( exp_paddr      ),
        .exp_ex_valid_i ( exp_exv        ),
        .exp_cause_i    ( exp_cause      ),
        .exp_tval_i     ( exp_tval       ),
        .exp_miss_i     ( exp_miss       ),
        .dtlb_hit_i     ( dtlb_hit       ),
        .dtlb_ppn_i     ( dtlb_ppn       ),
        .valid_i        ( lsu_valid      ),
        .paddr_i        ( lsu_paddr      ),
        .ex_valid_i     ( ex_valid       ),
        .ex_cause_i     ( ex_cause       ),
        .ex_tval_i      ( ex_tval        ),
        .miss_i         ( dtlb_miss      ),
        .error_count_o  ( checker_errors )
    );

    // ------------------------------------------------------------------------
    // drive helpers, all inputs change 1 ns after the rising edge
    // ------------------------------------------------------------------------
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic clear_strobes;
        lsu_req   = 1'b0;
        mis_valid = 1'b0;
        upd_valid = 1'b0;
        flush_tlb = 1'b0;
        chk       = 1'b0;
    endtask

    // the result stage reads the live config, so let the pipe drain first
    task automatic apply_config;
        clear_strobes();
        next_cycle();
        en_xlate = fld[0][0];
        priv_lvl = priv_lvl_e'(fld[1][1:0]);
        sum      = fld[2][0];
        asid     = fld[3][`MMU_ASIDW-1:0];
        next_cycle();
    endtask

    task automatic apply_flush;
        clear_strobes();
        flush_tlb = 1'b1;
        next_cycle();
    endtask

    task automatic apply_update;
        clear_strobes();
        upd_valid = 1'b1;
        upd_vpn   = fld[0][3*`MMU_VPN_LVL-1:0];
        upd_asid  = fld[1][`MMU_ASIDW-1:0];
        upd_ppn   = fld[2][`MMU_PPNW-1:0];
        upd_perm  = fld[3][3:0];
        upd_2m    = fld[4][0];
        upd_1g    = fld[5][0];
        next_cycle();
    endtask

    task automatic apply_request;
        clear_strobes();
        lsu_req      = fld[0][0];
        lsu_vaddr    = fld[1][`MMU_VLEN-1:0];
        lsu_is_store = fld[2][0];
        mis_valid    = fld[3][0];
        mis_cause    = fld[4][5:0];
        mis_tval     = fld[5];
        // expected values travel with the check strobe
        chk          = 1'b1;
        exp_hit      = fld[6][0];
        exp_dppn     = fld[7][`MMU_PPNW-1:0];
        exp_valid    = fld[8][0];
        exp_paddr    = fld[9][`MMU_PLEN-1:0];
        exp_exv      = fld[10][0];
        exp_cause    = fld[11][5:0];
        exp_tval     = fld[12];
        exp_miss     = fld[13][0];
        next_cycle();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int               fd;
        int               n;
        int               ops;
        int               wait_cnt;
        logic             done;
        logic             bad;
        logic [63:0]      op_tok;
        logic [8*128-1:0] rest;
        en_xlate     = 1'b0;
        asid         = '0;
        lsu_vaddr    = '0;
        lsu_is_store = 1'b0;
        mis_cause    = '0;
        mis_tval     = '0;
        priv_lvl     = PRIV_U;
        sum          = 1'b0;
        upd_vpn      = '0;
        upd_asid     = '0;
        upd_ppn      = '0;
        upd_perm     = '0;
        upd_2m       = 1'b0;
        upd_1g       = 1'b0;
        exp_hit      = 1'b0;
        exp_dppn     = '0;
        exp_valid    = 1'b0;
        exp_paddr    = '0;
        exp_exv      = 1'b0;
        exp_cause    = '0;
        exp_tval     = '0;
        exp_miss     = 1'b0;
        clear_strobes();
        tb_errors = 0;

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end

        if (rst_n !== 1'b1) begin
            $display("ERROR: reset was not released within %0d cycles", RESET_TIMEOUT);
            tb_errors++;
        end else begin
            fd = $fopen("mmu_stimulus.txt", "r");
            if (fd == 0) begin
                $display("ERROR: the stimulus file mmu_stimulus.txt could not be opened");
                tb_errors++;
            end else begin
                next_cycle();
                done = 1'b0;
                ops  = 0;
                while (!done) begin
                    n = $fscanf(fd, "%s", op_tok);
                    if (n != 1) begin
                        // end of file
                        done = 1'b1;
                    end else if (ops >= OP_LIMIT) begin
                        $display("ERROR: stimulus file did not end within %0d lines", OP_LIMIT);
                        tb_errors++;
                        done = 1'b1;
                    end else begin
                        ops++;
                        bad = 1'b0;
                        case (op_tok)
                            "#": n = $fgets(rest, fd);
                            "f": apply_flush();
                            "c": begin
                                n = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
                                if (n == 4) apply_config();
                                else bad = 1'b1;
                            end
                            "u": begin
                                n = $fscanf(fd, "%h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                            fld[3], fld[4], fld[5]);
                                if (n == 6) apply_update();
                                else bad = 1'b1;
                            end
                            "r": begin
                                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                            fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                                            fld[12], fld[13]);
                                if (n == 14) apply_request();
                                else bad = 1'b1;
                            end
                            default: bad = 1'b1;
                        endcase
                        if (bad) begin
                            $display("ERROR: stimulus line %0d could not be parsed", ops);
                            tb_errors++;
                            done = 1'b1;
                        end
                    end
                end
                $fclose(fd);
            end
        end

        // let the last result retire
        clear_strobes();
        repeat (3) next_cycle();
        i_checker.print_summary(tb_errors);
        if (checker_errors + tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
